//--- Bender.yml
package:
  name: z80_core

sources:
  - include_dirs:
      - include
    files:
      - verilog/z80_pkg.sv
      - verilog/z80_alu.sv
      - verilog/z80_regfile.sv
      - verilog/z80_control.sv
      - verilog/z80_core.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/z80_asserts.sv
      - sim/z80_tb.sv

//--- include/z80_params.svh
`ifndef Z80_PARAMS_SVH
`define Z80_PARAMS_SVH

// Flag register bit positions
`define FLAG_C      0
`define FLAG_N      1
`define FLAG_PV     2
`define FLAG_H      4
`define FLAG_Z      6
`define FLAG_S      7

// Register codes as in the opcode operand fields
`define REG_B       3'd0
`define REG_C       3'd1
`define REG_D       3'd2
`define REG_E       3'd3
`define REG_H       3'd4
`define REG_L       3'd5
`define REG_A       3'd7

// First fetch after reset
`define RESET_PC    16'h0000

// 01_110_110, the LD (HL),(HL) slot
`define OPC_HALT    8'h76

`endif

//--- sim/z80_asserts.sv
`timescale 1ns/1ps

module z80_core_asserts (
    input logic pin_clk,
    input logic rst_i,
    input logic mem_we_i,
    input logic io_we_i,
    input logic halt_i
);
    int unsigned fail_count = 0;                 // Failed assertion count

    we_exclusive: assert property (@(posedge pin_clk) disable iff (rst_i)
        !(mem_we_i && io_we_i))
        else begin
            fail_count++;
            $error("memory and I/O write strobes high in the same cycle");
        end

    // First cycle out of reset is quiet
    quiet_after_reset: assert property (@(posedge pin_clk)
        rst_i |=> !mem_we_i && !io_we_i)
        else begin
            fail_count++;
            $error("write strobe high in the cycle after reset");
        end

    halt_sticky: assert property (@(posedge pin_clk) disable iff (rst_i)
        halt_i |=> halt_i && !mem_we_i && !io_we_i)
        else begin
            fail_count++;
            $error("halt_o dropped or a strobe fired while halted");
        end

endmodule

bind z80_core z80_core_asserts asserts0 (
    .pin_clk  (pin_clk),
    .rst_i    (rst_i),
    .mem_we_i (mem_we_o),
    .io_we_i  (io_we_o),
    .halt_i   (halt_o)
);

//--- sim/z80_tb.sv
`timescale 1ns/1ps
`include "z80_params.svh"

module z80_tb;
    import z80_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int RST_CYCLES  = 2;
    localparam int RUN_CYCLES  = 40;             // Longest ALU program with a register operand
    localparam int HOLD_CYCLES = 10;
    localparam int ROW_CYCLES  = RST_CYCLES + RUN_CYCLES + HOLD_CYCLES + 4;
    localparam int NUM_ROWS    = 20;

    localparam logic [1:0] K_ALU  = 2'd0;
    localparam logic [1:0] K_MOVE = 2'd1;
    localparam logic [1:0] K_MEM  = 2'd2;
    localparam logic [1:0] K_IN   = 2'd3;

    // {kind, ALU op, selector} per row
    // Selector 6 takes an immediate and the others name a register
    localparam logic [7:0] ROW_SPEC [NUM_ROWS] = '{
        {K_ALU, 3'd0, 3'd6}, {K_ALU, 3'd0, 3'd0}, {K_ALU, 3'd1, 3'd6}, {K_ALU, 3'd1, 3'd7},
        {K_ALU, 3'd2, 3'd6}, {K_ALU, 3'd2, 3'd7}, {K_ALU, 3'd3, 3'd6}, {K_ALU, 3'd3, 3'd1},
        {K_ALU, 3'd4, 3'd6}, {K_ALU, 3'd4, 3'd2}, {K_ALU, 3'd5, 3'd6}, {K_ALU, 3'd5, 3'd3},
        {K_ALU, 3'd6, 3'd6}, {K_ALU, 3'd6, 3'd4}, {K_ALU, 3'd7, 3'd6}, {K_ALU, 3'd7, 3'd5},
        {K_ALU, 3'd7, 3'd7}, {K_MOVE, 3'd0, 3'd0}, {K_MEM, 3'd0, 3'd0}, {K_IN, 3'd0, 3'd0}
    };

    logic  pin_clk = 1'b0;
    logic  rst_i   = 1'b1;
    addr_t mem_addr;
    byte_t mem_rdata;
    byte_t mem_wdata;
    logic  mem_we;
    byte_t io_addr;
    byte_t io_wdata;
    byte_t io_rdata;
    logic  io_we;
    logic  halt;

    byte_t       mem [65536];
    byte_t       io_ports [256];
    logic [31:0] lfsr_q = 32'h968a_aef2;
    addr_t       wp;                             // Program write pointer

    byte_t op_a [NUM_ROWS];
    byte_t op_b [NUM_ROWS];
    addr_t row_addr [NUM_ROWS];
    byte_t exp_val [NUM_ROWS][3];                // Expected OUT data for ports 10h upwards
    int    exp_outs [NUM_ROWS];

    byte_t out_port [$];
    byte_t out_data [$];
    addr_t wr_addr [$];
    byte_t wr_data [$];

    always #(CLK_PERIOD / 2) pin_clk = ~pin_clk;

    z80_core dut0 (
        .pin_clk    (pin_clk),
        .rst_i      (rst_i),
        .mem_addr_o (mem_addr),
        .mem_data_i (mem_rdata),
        .mem_data_o (mem_wdata),
        .mem_we_o   (mem_we),
        .io_addr_o  (io_addr),
        .io_data_o  (io_wdata),
        .io_data_i  (io_rdata),
        .io_we_o    (io_we),
        .halt_o     (halt)
    );

    assign mem_rdata = mem[mem_addr];            // Same-cycle read
    assign io_rdata  = io_ports[io_addr];

    always @(posedge pin_clk) begin
        if (mem_we) mem[mem_addr] <= mem_wdata;
    end

    // Strobes are sampled mid-cycle
    always @(negedge pin_clk) begin
        if (!rst_i && io_we) begin
            out_port.push_back(io_addr);
            out_data.push_back(io_wdata);
        end
        if (!rst_i && mem_we) begin
            wr_addr.push_back(mem_addr);
            wr_data.push_back(mem_wdata);
        end
    end

    always @(negedge pin_clk) begin
        if (dut0.asserts0.fail_count != 0) begin
            $display("A bus assertion in the bound checker failed");
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    // Returns {carry, zero, result} of an accumulator operation
    function automatic logic [9:0] alu_model(input logic [2:0] op, input byte_t a,
                                             input byte_t b, input logic cin);
        int   ai;
        int   bi;
        int   ci;
        int   r;
        logic c;
        ai = a;
        bi = b;
        ci = cin;
        c  = 1'b0;
        case (op)
            3'd0:       r = ai + bi;
            3'd1:       r = ai + bi + ci;
            3'd2, 3'd7: r = ai - bi;             // SUB and CP
            3'd3:       r = ai - bi - ci;
            3'd4:       r = ai & bi;
            3'd5:       r = ai ^ bi;
            default:    r = ai | bi;
        endcase
        if (op < 3'd4 || op == 3'd7) c = (r < 0) || (r > 255);   // Logic ops clear C
        return {c, r[7:0] == 8'h00, r[7:0]};
    endfunction

    task automatic build_table();
        logic [31:0] v;
        logic [2:0]  op;
        logic [9:0]  pre;
        logic [9:0]  m;
        byte_t       inc;
        for (int i = 0; i < NUM_ROWS; i++) begin
            draw_bits(8, v);
            op_a[i] = v[7:0];
            draw_bits(8, v);
            op_b[i] = v[7:0];
            draw_bits(15, v);
            row_addr[i] = {1'b1, v[14:0]};       // Upper half clear of the programs
            op          = ROW_SPEC[i][5:3];
            exp_outs[i] = 1;
            case (ROW_SPEC[i][7:6])
                K_ALU: begin
                    pre = alu_model(3'd0, op_a[i], op_b[i], 1'b0);   // Carry of ADD A,b
                    m   = alu_model(op, op_a[i], (ROW_SPEC[i][2:0] == 3'd7) ? op_a[i] : op_b[i],
                                    pre[9]);
                    exp_val[i][0] = (op == 3'd7) ? op_a[i] : m[7:0];
                    exp_val[i][1] = {7'd0, m[8]};
                    exp_val[i][2] = {7'd0, m[9]};
                    exp_outs[i]   = 3;
                end
                K_MOVE: begin
                    m   = alu_model(3'd0, op_a[i], 8'd1, 1'b0);      // INC C
                    inc = m[7:0];
                    m   = alu_model(3'd2, op_a[i], 8'd1, 1'b0);      // DEC B
                    m   = alu_model(3'd0, inc, m[7:0], 1'b0);
                    exp_val[i][0] = inc;
                    exp_val[i][1] = m[7:0];
                    exp_outs[i]   = 2;
                end
                default: exp_val[i][0] = op_a[i];  // Memory and IN echo operand a
            endcase
        end
    endtask

    task automatic emit(input byte_t b);
        mem[wp] = b;
        wp      = wp + 16'd1;
    endtask

    task automatic emit_pair(input byte_t b0, input byte_t b1);
        emit(b0);
        emit(b1);
    endtask

    task automatic load_program(input int i);
        logic [2:0] op;
        logic [2:0] sel;
        addr_t      tgt;
        op  = ROW_SPEC[i][5:3];
        sel = ROW_SPEC[i][2:0];
        wp  = `RESET_PC;
        case (ROW_SPEC[i][7:6])
            K_ALU: begin
                emit_pair(8'h3E, op_a[i]);
                emit_pair(8'hC6, op_b[i]);       // ADD A,b leaves a carry for ADC and SBC
                if (sel < 3'd6) emit_pair({2'b00, sel, 3'b110}, op_b[i]);
                emit_pair(8'h3E, op_a[i]);
                if (sel == 3'd6) begin
                    emit_pair({2'b11, op, 3'b110}, op_b[i]);
                end else begin
                    emit({2'b10, op, sel});
                end
                emit_pair(8'hD3, 8'h10);
                emit_pair(8'h3E, 8'h01);
                emit_pair(8'h28, 8'h02);         // JR Z over LD A,0
                emit_pair(8'h3E, 8'h00);
                emit_pair(8'hD3, 8'h11);
                emit_pair(8'h3E, 8'h01);
                tgt = wp + 16'd5;
                emit(8'hDA);                     // JP C over LD A,0
                emit_pair(tgt[7:0], tgt[15:8]);
                emit_pair(8'h3E, 8'h00);
                emit_pair(8'hD3, 8'h12);
            end
            K_MOVE: begin
                emit_pair({2'b00, `REG_B, 3'b110}, op_a[i]);
                emit({2'b01, `REG_C, `REG_B});
                emit({2'b00, `REG_C, 3'b100});
                emit({2'b00, `REG_B, 3'b101});
                emit({2'b01, `REG_A, `REG_C});
                emit_pair(8'hD3, 8'h10);         // C after INC
                emit({5'b10000, `REG_B});
                emit_pair(8'hD3, 8'h11);
            end
            K_MEM: begin
                emit_pair(8'h3E, op_a[i]);
                emit(8'h32);
                emit_pair(row_addr[i][7:0], row_addr[i][15:8]);
                emit_pair(8'h3E, ~op_a[i]);      // A differs from the stored byte before the load
                emit(8'h3A);
                emit_pair(row_addr[i][7:0], row_addr[i][15:8]);
                emit_pair(8'hD3, 8'h10);
            end
            default: begin
                io_ports[op_b[i]] = op_a[i];
                emit_pair(8'hDB, op_b[i]);
                emit_pair(8'hD3, 8'h10);
            end
        endcase
        emit(`OPC_HALT);
    endtask

    task automatic run_row(input int i);
        logic is_mem;
        is_mem = (ROW_SPEC[i][7:6] == K_MEM);
        @(negedge pin_clk);
        rst_i = 1'b1;
        out_port.delete();
        out_data.delete();
        wr_addr.delete();
        wr_data.delete();
        load_program(i);
        repeat (RST_CYCLES) @(negedge pin_clk);
        rst_i = 1'b0;
        while (!halt) @(negedge pin_clk);
        for (int k = 0; k < HOLD_CYCLES; k++) begin
            @(negedge pin_clk);
            check_value(halt, 1, $sformatf("row %0d halt_o dropped after HALT", i));
            check_value({mem_we, io_we}, 0, $sformatf("row %0d strobe while halted", i));
        end
        check_value(out_data.size(), exp_outs[i], $sformatf("row %0d OUT count", i));
        for (int k = 0; k < exp_outs[i]; k++) begin
            check_value(out_port[k], 8'h10 + k, $sformatf("row %0d OUT %0d port", i, k));
            check_value(out_data[k], exp_val[i][k], $sformatf("row %0d OUT %0d data", i, k));
        end
        check_value(wr_addr.size(), is_mem, $sformatf("row %0d memory write count", i));
        if (is_mem) begin
            check_value(wr_addr[0], row_addr[i], $sformatf("row %0d write address", i));
            check_value(wr_data[0], op_a[i], $sformatf("row %0d write data", i));
        end
    endtask

    initial begin
        for (int a = 0; a < 65536; a++) mem[a] = a[15:8] ^ a[7:0] ^ 8'hA5;
        for (int p = 0; p < 256; p++) io_ports[p] = ~p[7:0];
        build_table();
        for (int i = 0; i < NUM_ROWS; i++) run_row(i);
        if (dut0.asserts0.fail_count != 0) begin
            $display("%0d bus assertions failed", dut0.asserts0.fail_count);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

    initial begin
        #(NUM_ROWS * ROW_CYCLES * CLK_PERIOD);
        $display("Timeout: the core never reached HALT");
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

endmodule

//--- verilog/z80_alu.sv
`timescale 1ns/1ps
`include "z80_params.svh"

module z80_alu (
    input  z80_pkg::alu_op_e alu_op_i,
    input  z80_pkg::byte_t   op_a_i,
    input  z80_pkg::byte_t   op_b_i,
    input  logic             carry_in_i,
    output z80_pkg::byte_t   alu_res_o,
    output z80_pkg::flags_t  alu_flags_o
);
    import z80_pkg::*;

    logic       sub;          // SUB, SBC and CP
    logic       arith;        // Adder result selected
    logic       use_carry;    // ADC and SBC
    logic       cin;          // Carry into bit 0
    byte_t      b_eff;        // Second adder input
    logic [4:0] half;         // Low nibble sum
    logic [8:0] full;         // Byte sum with carry out
    logic       ovf;
    byte_t      res;

    assign sub       = (alu_op_i == ALU_SUB) || (alu_op_i == ALU_SBC) || (alu_op_i == ALU_CP);
    assign arith     = sub || (alu_op_i == ALU_ADD) || (alu_op_i == ALU_ADC);
    assign use_carry = (alu_op_i == ALU_ADC) || (alu_op_i == ALU_SBC);

    // One adder for both directions, a - b - c is a + ~b + !c
    assign b_eff = sub ? ~op_b_i : op_b_i;
    assign cin   = sub ^ (use_carry && carry_in_i);

    assign half = {1'b0, op_a_i[3:0]} + {1'b0, b_eff[3:0]} + 5'(cin);
    assign full = {1'b0, op_a_i} + {1'b0, b_eff} + 9'(cin);

    // Same input signs, different result sign
    assign ovf = (op_a_i[7] == b_eff[7]) && (full[7] != op_a_i[7]);

    always_comb begin
        case (alu_op_i)
            ALU_AND: res = op_a_i & op_b_i;
            ALU_XOR: res = op_a_i ^ op_b_i;
            ALU_OR:  res = op_a_i | op_b_i;
            default: res = full[7:0];           // ADD, ADC, SUB, SBC, CP
        endcase
    end

    always_comb begin
        alu_flags_o            = '0;
        alu_flags_o[`FLAG_S]   = res[7];
        alu_flags_o[`FLAG_Z]   = (res == 8'h00);
        alu_flags_o[5]         = res[5];         // Undocumented copy
        alu_flags_o[3]         = res[3];         // Undocumented copy
        alu_flags_o[`FLAG_N]   = sub;

        // Borrow is the inverted carry when subtracting
        if (arith) begin
            alu_flags_o[`FLAG_H]  = half[4] ^ sub;
            alu_flags_o[`FLAG_PV] = ovf;
            alu_flags_o[`FLAG_C]  = full[8] ^ sub;
        end else begin
            alu_flags_o[`FLAG_H]  = (alu_op_i == ALU_AND);
            alu_flags_o[`FLAG_PV] = ~^res;      // Even parity
            alu_flags_o[`FLAG_C]  = 1'b0;
        end
    end

    assign alu_res_o = res;

endmodule

//--- verilog/z80_control.sv
`timescale 1ns/1ps
`include "z80_params.svh"

module z80_control (
    input  logic              pin_clk,
    input  logic              rst_i,
    input  z80_pkg::byte_t    mem_data_i,
    input  z80_pkg::byte_t    io_data_i,
    input  z80_pkg::byte_t    rd_data_i,
    input  z80_pkg::byte_t    a_val_i,
    input  z80_pkg::byte_t    alu_res_i,
    input  z80_pkg::flags_t   alu_flags_i,
    output z80_pkg::addr_t    mem_addr_o,
    output z80_pkg::byte_t    mem_data_o,
    output logic              mem_we_o,
    output z80_pkg::byte_t    io_addr_o,
    output z80_pkg::byte_t    io_data_o,
    output logic              io_we_o,
    output logic              halt_o,
    output z80_pkg::reg_sel_t rd_sel_o,
    output z80_pkg::reg_sel_t wr_sel_o,
    output logic              wr_en_o,
    output z80_pkg::byte_t    wr_data_o,
    output z80_pkg::alu_op_e  alu_op_o,
    output z80_pkg::byte_t    op_a_o,
    output z80_pkg::byte_t    op_b_o,
    output logic              carry_in_o
);
    import z80_pkg::*;

    addr_t  pc_q;
    flags_t f_q;
    step_e  step_q;
    byte_t  opc_q;           // Opcode held after T0
    addr_t  nn_q;            // Address for (nn) and JP
    byte_t  imm_q;           // Immediate or register operand
    byte_t  io_addr_q;
    byte_t  io_data_q;
    logic   io_we_q;
    logic   in_pend_q;       // IN writes A one cycle after the port address
    logic   halt_q;

    byte_t  opcode;
    logic   is_ld_ri;
    logic   is_incdec;
    logic   is_ld_rr;
    logic   is_alu_r;
    logic   is_alu_i;
    logic   is_alu;
    logic   is_ld_a_nn;
    logic   is_ld_nn_a;
    logic   is_jp;
    logic   is_jr;
    logic   is_out;
    logic   is_in;
    logic   has_arg;         // Operand byte follows the opcode
    logic   nn_op;           // Two address bytes follow
    logic   multi_step;
    logic   cond_ok;
    logic   take;
    addr_t  pc_next;
    addr_t  pc_rel;

    // T0 decodes straight from the bus
    assign opcode = (step_q == T0) ? mem_data_i : opc_q;

    assign is_ld_ri   = (opcode ==? 8'b00???110) && (opcode[5:3] != 3'd6);
    assign is_incdec  = (opcode ==? 8'b00???10?) && (opcode[5:3] != 3'd6);
    assign is_ld_rr   = (opcode[7:6] == 2'b01) && (opcode[5:3] != 3'd6)
                        && (opcode[2:0] != 3'd6);
    assign is_alu_r   = (opcode[7:6] == 2'b10) && (opcode[2:0] != 3'd6);
    assign is_alu_i   = (opcode ==? 8'b11???110);
    assign is_alu     = is_alu_r || is_alu_i;
    assign is_ld_a_nn = (opcode == 8'h3A);
    assign is_ld_nn_a = (opcode == 8'h32);
    assign is_jp      = (opcode == 8'hC3) || (opcode ==? 8'b110??010);
    assign is_jr      = (opcode == 8'h18) || (opcode ==? 8'b001??000);
    assign is_out     = (opcode == 8'hD3);
    assign is_in      = (opcode == 8'hDB);

    assign nn_op      = is_ld_a_nn || is_ld_nn_a || is_jp;
    assign has_arg    = is_ld_ri || is_alu_i || nn_op || is_out || is_in;
    assign multi_step = has_arg || is_incdec || is_ld_rr || is_alu_r || is_jr;

    // Bit 4 picks C or Z, bit 3 the wanted value
    assign cond_ok = opcode[4] ? (f_q[`FLAG_C] == opcode[3]) : (f_q[`FLAG_Z] == opcode[3]);
    assign take    = (opcode == 8'h18) || (opcode == 8'hC3) || cond_ok;
    assign pc_next = pc_q + 16'd1;
    assign pc_rel  = pc_next + {{8{mem_data_i[7]}}, mem_data_i};

    always_ff @(posedge pin_clk) begin
        if (rst_i) begin
            pc_q      <= `RESET_PC;
            f_q       <= '0;
            step_q    <= T0;
            io_we_q   <= 1'b0;
            in_pend_q <= 1'b0;
            halt_q    <= 1'b0;
        end else begin
            io_we_q   <= 1'b0;
            in_pend_q <= 1'b0;
            step_q    <= T0;
            case (step_q)
                T0: if (!halt_q) begin
                    if (opcode == `OPC_HALT) begin
                        halt_q <= 1'b1;                 // PC stays on the HALT
                    end else begin
                        pc_q <= pc_next;
                        if (multi_step) step_q <= T1;
                    end
                end
                T1: begin
                    if (has_arg) pc_q <= pc_next;
                    if (is_jr) pc_q <= take ? pc_rel : pc_next;
                    if (is_ld_ri || is_alu || nn_op) step_q <= T2;
                    if (is_incdec) begin
                        f_q          <= alu_flags_i;
                        f_q[`FLAG_C] <= f_q[`FLAG_C];   // INC and DEC keep carry
                    end
                    io_we_q   <= is_out;
                    in_pend_q <= is_in;
                end
                T2: begin
                    if (nn_op) begin
                        pc_q   <= pc_next;
                        step_q <= T3;
                    end
                    if (is_alu) f_q <= alu_flags_i;
                end
                T3: if (is_jp && take) pc_q <= nn_q;
                default: ;
            endcase
        end
    end

    always_ff @(posedge pin_clk) begin
        if (step_q == T0) opc_q <= mem_data_i;
        if (step_q == T1) begin
            imm_q     <= is_alu_r ? rd_data_i : mem_data_i;
            nn_q[7:0] <= mem_data_i;                    // Low byte first
        end
        if (step_q == T2) nn_q[15:8] <= mem_data_i;
        if (step_q == T1 && (is_out || is_in)) io_addr_q <= mem_data_i;
        if (step_q == T1 && is_out) io_data_q <= a_val_i;
    end

    // Memory bus, address latch only in the data step of (nn)
    assign mem_addr_o = (step_q == T3 && (is_ld_a_nn || is_ld_nn_a)) ? nn_q : pc_q;
    assign mem_data_o = a_val_i;
    assign mem_we_o   = (step_q == T3) && is_ld_nn_a;

    assign io_addr_o  = io_addr_q;
    assign io_data_o  = io_data_q;
    assign io_we_o    = io_we_q;
    assign halt_o     = halt_q;

    assign rd_sel_o   = is_incdec ? opcode[5:3] : opcode[2:0];
    assign alu_op_o   = is_incdec ? (opcode[0] ? ALU_SUB : ALU_ADD) : alu_op_e'(opcode[5:3]);
    assign op_a_o     = is_incdec ? rd_data_i : a_val_i;
    assign op_b_o     = is_incdec ? 8'd1 : imm_q;
    assign carry_in_o = f_q[`FLAG_C];

    always_comb begin
        wr_en_o   = 1'b0;
        wr_sel_o  = opcode[5:3];
        wr_data_o = alu_res_i;
        if (in_pend_q) begin
            wr_en_o   = 1'b1;                           // Lands in the next T0
            wr_sel_o  = `REG_A;
            wr_data_o = io_data_i;
        end else begin
            case (step_q)
                T1: begin
                    wr_en_o = is_incdec || is_ld_rr;
                    if (is_ld_rr) wr_data_o = rd_data_i;
                end
                T2: begin
                    if (is_ld_ri) begin
                        wr_en_o   = 1'b1;
                        wr_data_o = imm_q;
                    end
                    if (is_alu) begin
                        wr_en_o  = (alu_op_o != ALU_CP);   // CP only sets flags
                        wr_sel_o = `REG_A;
                    end
                end
                T3: begin
                    if (is_ld_a_nn) begin
                        wr_en_o   = 1'b1;
                        wr_sel_o  = `REG_A;
                        wr_data_o = mem_data_i;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

//--- verilog/z80_core.sv
`timescale 1ns/1ps

module z80_core (
    input  logic           pin_clk,
    input  logic           rst_i,
    output z80_pkg::addr_t mem_addr_o,
    input  z80_pkg::byte_t mem_data_i,
    output z80_pkg::byte_t mem_data_o,
    output logic           mem_we_o,
    output z80_pkg::byte_t io_addr_o,
    output z80_pkg::byte_t io_data_o,
    input  z80_pkg::byte_t io_data_i,
    output logic           io_we_o,
    output logic           halt_o
);
    import z80_pkg::*;

    reg_sel_t rd_sel;
    reg_sel_t wr_sel;
    logic     wr_en;
    byte_t    wr_data;
    byte_t    rd_data;
    byte_t    a_val;         // Accumulator side port
    alu_op_e  alu_op;
    byte_t    op_a;
    byte_t    op_b;
    logic     carry_in;
    byte_t    alu_res;
    flags_t   alu_flags;

    z80_control u_control (
        .pin_clk     (pin_clk),
        .rst_i       (rst_i),
        .mem_data_i  (mem_data_i),
        .io_data_i   (io_data_i),
        .rd_data_i   (rd_data),
        .a_val_i     (a_val),
        .alu_res_i   (alu_res),
        .alu_flags_i (alu_flags),
        .mem_addr_o  (mem_addr_o),
        .mem_data_o  (mem_data_o),
        .mem_we_o    (mem_we_o),
        .io_addr_o   (io_addr_o),
        .io_data_o   (io_data_o),
        .io_we_o     (io_we_o),
        .halt_o      (halt_o),
        .rd_sel_o    (rd_sel),
        .wr_sel_o    (wr_sel),
        .wr_en_o     (wr_en),
        .wr_data_o   (wr_data),
        .alu_op_o    (alu_op),
        .op_a_o      (op_a),
        .op_b_o      (op_b),
        .carry_in_o  (carry_in)
    );

    z80_regfile u_regfile (
        .pin_clk   (pin_clk),
        .rst_i     (rst_i),
        .rd_sel_i  (rd_sel),
        .wr_sel_i  (wr_sel),
        .wr_en_i   (wr_en),
        .wr_data_i (wr_data),
        .rd_data_o (rd_data),
        .a_val_o   (a_val)
    );

    z80_alu u_alu (
        .alu_op_i    (alu_op),
        .op_a_i      (op_a),
        .op_b_i      (op_b),
        .carry_in_i  (carry_in),
        .alu_res_o   (alu_res),
        .alu_flags_o (alu_flags)
    );

endmodule

//--- verilog/z80_pkg.sv
package z80_pkg;

    typedef logic [7:0]  byte_t;      // Data byte
    typedef logic [15:0] addr_t;      // Memory address
    typedef logic [7:0]  flags_t;     // S Z Y H X PV N C
    typedef logic [2:0]  reg_sel_t;   // Register code

    // Order follows opcode bits 5..3 of the ALU group
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_XOR,
        ALU_OR,
        ALU_CP
    } alu_op_e;

    // Instruction step, T0 is the opcode fetch
    typedef enum logic [2:0] {
        T0,
        T1,
        T2,
        T3
    } step_e;

endpackage

//--- verilog/z80_regfile.sv
`timescale 1ns/1ps
`include "z80_params.svh"

module z80_regfile (
    input  logic              pin_clk,
    input  logic              rst_i,
    input  z80_pkg::reg_sel_t rd_sel_i,
    input  z80_pkg::reg_sel_t wr_sel_i,
    input  logic              wr_en_i,
    input  z80_pkg::byte_t    wr_data_i,
    output z80_pkg::byte_t    rd_data_o,
    output z80_pkg::byte_t    a_val_o
);
    import z80_pkg::*;

    byte_t b_q;
    byte_t c_q;
    byte_t d_q;
    byte_t e_q;
    byte_t h_q;
    byte_t l_q;
    byte_t a_q;

    always_ff @(posedge pin_clk) begin
        if (rst_i) begin
            b_q <= '0;
            c_q <= '0;
            d_q <= '0;
            e_q <= '0;
            h_q <= '0;
            l_q <= '0;
            a_q <= '0;
        end else if (wr_en_i) begin
            case (wr_sel_i)
                `REG_B:  b_q <= wr_data_i;
                `REG_C:  c_q <= wr_data_i;
                `REG_D:  d_q <= wr_data_i;
                `REG_E:  e_q <= wr_data_i;
                `REG_H:  h_q <= wr_data_i;
                `REG_L:  l_q <= wr_data_i;
                `REG_A:  a_q <= wr_data_i;
                default: ;                      // Code 6 is (HL), no register
            endcase
        end
    end

    always_comb begin
        case (rd_sel_i)
            `REG_B:  rd_data_o = b_q;
            `REG_C:  rd_data_o = c_q;
            `REG_D:  rd_data_o = d_q;
            `REG_E:  rd_data_o = e_q;
            `REG_H:  rd_data_o = h_q;
            `REG_L:  rd_data_o = l_q;
            `REG_A:  rd_data_o = a_q;
            default: rd_data_o = '0;
        endcase
    end

    assign a_val_o = a_q;                       // Accumulator always visible

endmodule

//--- vlog.f
+incdir+include
verilog/z80_pkg.sv
verilog/z80_alu.sv
verilog/z80_regfile.sv
verilog/z80_control.sv
verilog/z80_core.sv
sim/z80_asserts.sv
sim/z80_tb.sv
